/* Makefile */
# Verilator build and run of the copy chain testbench
OBJ := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -f copy_chain.f \
		--top-module copy_chain_tb -Mdir $(OBJ)
	./$(OBJ)/Vcopy_chain_tb

clean:
	rm -rf $(OBJ)

/* copy_chain.f */
+incdir+design
design/stream_pkg.sv
design/copy_pkg.sv
design/copy_source.sv
design/copy_slice.sv
design/copy_sink.sv
design/copy_chain_top.sv
verification/copy_chain_asserts.sv
verification/copy_chain_tb.sv

/* design/copy_chain_cfg.svh */
// width and depth macros for the copy chain, include wherever a width or the slice count is needed
`ifndef COPY_CHAIN_CFG_SVH
`define COPY_CHAIN_CFG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// original stream
// data bits per beat, one word
`define CC_DATA_W 32
// one strobe bit per data byte
`define CC_STRB_W (`CC_DATA_W / 8)

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// copy stream
// sized for parity mode, raise to CC_DATA_W for a full copy
`define CC_COPY_W `CC_STRB_W

// register slices between source and sink
`define CC_NUM_SLICES 3

`endif

/* design/copy_chain_top.sv */
// top of the protected stream pipeline, source then a chain of slices then the checking sink
`timescale 1ns/1ps
`include "copy_chain_cfg.svh"

module copy_chain_top import stream_pkg::*, copy_pkg::*; #(
  parameter copy_mode_e MODE = CM_PARITY
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       in_valid_i,
  output logic       in_ready_o,
  input  orig_beat_t in_beat_i,
  input  logic       inject_i,     // self-test, corrupts one copy beat
  output logic       out_valid_o,
  input  logic       out_ready_i,
  output orig_beat_t out_beat_o,
  input  logic       clear_i,
  output logic       fault_o,
  output logic       alarm_o
);

  localparam int unsigned N = `CC_NUM_SLICES;

  // forward halves of a link, ready runs the other way
  typedef struct packed {
    logic       valid;
    orig_beat_t beat;
  } orig_link_t;

  typedef struct packed {
    logic       valid;
    copy_beat_t beat;
  } copy_link_t;

  orig_link_t orig_link [N+1];  // 0 from source, N into sink
  copy_link_t copy_link [N+1];
  logic [N:0] link_ready;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // source

  copy_source #(.MODE(MODE)) u_source (
    .in_valid_i   (in_valid_i),
    .in_ready_o   (in_ready_o),
    .in_beat_i    (in_beat_i),
    .inject_i     (inject_i),
    .orig_valid_o (orig_link[0].valid),
    .orig_beat_o  (orig_link[0].beat),
    .copy_valid_o (copy_link[0].valid),
    .copy_beat_o  (copy_link[0].beat),
    .ready_i      (link_ready[0])
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // slice chain

  for (genvar i = 0; i < N; i++) begin : g_slice
    copy_slice u_slice (
      .clk_i           (clk_i),
      .rst_ni          (rst_ni),
      .up_orig_valid_i (orig_link[i].valid),
      .up_orig_beat_i  (orig_link[i].beat),
      .up_copy_valid_i (copy_link[i].valid),
      .up_copy_beat_i  (copy_link[i].beat),
      .up_ready_o      (link_ready[i]),
      .dn_orig_valid_o (orig_link[i+1].valid),
      .dn_orig_beat_o  (orig_link[i+1].beat),
      .dn_copy_valid_o (copy_link[i+1].valid),
      .dn_copy_beat_o  (copy_link[i+1].beat),
      .dn_ready_i      (link_ready[i+1])
    );
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // sink and outputs

  copy_sink #(.MODE(MODE)) u_sink (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .orig_valid_i (orig_link[N].valid),
    .orig_beat_i  (orig_link[N].beat),
    .copy_valid_i (copy_link[N].valid),
    .copy_beat_i  (copy_link[N].beat),
    .ready_i      (out_ready_i),
    .ready_o      (link_ready[N]),   // last slice sees the outside ready
    .clear_i      (clear_i),
    .fault_o      (fault_o),
    .alarm_o      (alarm_o)
  );

  assign out_valid_o = orig_link[N].valid;
  assign out_beat_o  = orig_link[N].beat;

endmodule

/* design/copy_pkg.sv */
// copy mode encoding and the beat reduction that source and sink both call
`include "copy_chain_cfg.svh"

package copy_pkg;

  import stream_pkg::*;

  // how deep the copy goes, must match on source and sink
  typedef enum logic [1:0] {
    CM_FULL   = 2'd0,  // data and strobe copied as is
    CM_PARITY = 2'd1,  // one parity bit per byte, strobe copied
    CM_STRB   = 2'd2,  // strobe only
    CM_ZERO   = 2'd3   // handshake only
  } copy_mode_e;

  localparam int unsigned BYTE_W = `CC_DATA_W / `CC_STRB_W;  // bits per strobe lane

  // reduce one original beat to its copy, unused bits stay zero
  function automatic copy_beat_t copy_of(orig_beat_t beat, copy_mode_e mode);
    copy_beat_t c;
    c = '0;
    case (mode)
      CM_FULL: begin
        for (int i = 0; i < `CC_COPY_W; i++) begin
          if (i < `CC_DATA_W) begin
            c.cdata[i] = beat.data[i];  // width checked in the source
          end
        end
        c.cstrb = beat.strb;
      end
      CM_PARITY: begin
        for (int i = 0; i < `CC_STRB_W; i++) begin
          if (i < `CC_COPY_W) begin
            c.cdata[i] = ^beat.data[i*BYTE_W +: BYTE_W];  // even parity of byte i
          end
        end
        c.cstrb = beat.strb;
      end
      CM_STRB: c.cstrb = beat.strb;
      default: c = '0;  // CM_ZERO, only the valid is carried
    endcase
    return c;
  endfunction

endpackage

/* design/copy_sink.sv */
// tail of the copy chain, recomputes the copy from the original and raises a registered fault and a sticky alarm
`timescale 1ns/1ps

module copy_sink import stream_pkg::*, copy_pkg::*; #(
  parameter copy_mode_e MODE = CM_PARITY  // must match the source
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       orig_valid_i,
  input  orig_beat_t orig_beat_i,
  input  logic       copy_valid_i,
  input  copy_beat_t copy_beat_i,
  input  logic       ready_i,     // downstream ready of the original
  output logic       ready_o,     // back into the last slice
  input  logic       clear_i,     // drops the alarm
  output logic       fault_o,
  output logic       alarm_o
);

  // which copy fields the mode carries
  localparam bit USE_DATA = (MODE == CM_FULL) || (MODE == CM_PARITY);
  localparam bit USE_STRB = (MODE != CM_ZERO);

  copy_beat_t ref_beat;     // copy rebuilt from the original
  logic       valid_fault;
  logic       data_fault;
  logic       strb_fault;
  logic       fault_d;

  // handshake straight through, the copy has no ready of its own
  assign ready_o = ready_i;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // compare

  assign ref_beat    = copy_of(orig_beat_i, MODE);
  assign valid_fault = orig_valid_i ^ copy_valid_i;

  // payload only means something while a beat is held
  assign data_fault = USE_DATA && orig_valid_i
                      && (copy_beat_i.cdata != ref_beat.cdata);
  assign strb_fault = USE_STRB && orig_valid_i
                      && (copy_beat_i.cstrb != ref_beat.cstrb);

  assign fault_d = valid_fault | data_fault | strb_fault;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // fault and alarm flops

  // registered so the compare tree stays off the output path
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fault_o <= 1'b0;
      alarm_o <= 1'b0;
    end else begin
      fault_o <= fault_d;
      alarm_o <= fault_d | (alarm_o & ~clear_i);  // new fault beats clear
    end
  end

endmodule

/* design/copy_slice.sv */
// one register stage of the chain, carries the original and its copy side by side in separate flops
`timescale 1ns/1ps

module copy_slice import stream_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  // upstream side
  input  logic       up_orig_valid_i,
  input  orig_beat_t up_orig_beat_i,
  input  logic       up_copy_valid_i,
  input  copy_beat_t up_copy_beat_i,
  output logic       up_ready_o,       // shared by both streams
  // downstream side
  output logic       dn_orig_valid_o,
  output orig_beat_t dn_orig_beat_o,
  output logic       dn_copy_valid_o,
  output copy_beat_t dn_copy_beat_o,
  input  logic       dn_ready_i        // original ready only
);

  logic       orig_valid_q;
  logic       copy_valid_q;  // own flop so a stray copy valid shows up
  orig_beat_t orig_beat_q;
  copy_beat_t copy_beat_q;
  logic       xfer;          // original beat accepted

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // handshake

  // free slot, or the held beat leaves this cycle
  assign up_ready_o = ~orig_valid_q | dn_ready_i;
  assign xfer       = up_orig_valid_i & up_ready_o;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // storage

  // valids refill whenever the slot opens, so both sides track each other
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      orig_valid_q <= 1'b0;
      copy_valid_q <= 1'b0;
    end else if (up_ready_o) begin
      orig_valid_q <= up_orig_valid_i;
      copy_valid_q <= up_copy_valid_i;  // taken even if it disagrees
    end
  end

  // payload moves on the original transfer, held under stall
  always_ff @(posedge clk_i) begin
    if (xfer) begin
      orig_beat_q <= up_orig_beat_i;
      copy_beat_q <= up_copy_beat_i;
    end
  end

  assign dn_orig_valid_o = orig_valid_q;
  assign dn_orig_beat_o  = orig_beat_q;
  assign dn_copy_valid_o = copy_valid_q;
  assign dn_copy_beat_o  = copy_beat_q;

endmodule

/* design/copy_source.sv */
// head of the copy chain, forwards the input stream and builds the copy beat with optional self-test corruption
`timescale 1ns/1ps
`include "copy_chain_cfg.svh"

module copy_source import stream_pkg::*, copy_pkg::*; #(
  parameter copy_mode_e MODE = CM_PARITY  // must match the sink
) (
  input  logic       in_valid_i,
  output logic       in_ready_o,
  input  orig_beat_t in_beat_i,
  input  logic       inject_i,      // corrupt the copy of this beat
  output logic       orig_valid_o,
  output orig_beat_t orig_beat_o,
  output logic       copy_valid_o,
  output copy_beat_t copy_beat_o,
  input  logic       ready_i        // shared ready from the first slice
);

  logic       accept;      // beat moves this cycle
  logic       corrupt;     // self-test hits this beat
  copy_beat_t copy_clean;  // copy before any corruption

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // elaboration checks on the copy width

  if (MODE == CM_FULL && `CC_COPY_W < `CC_DATA_W) begin : g_chk_full
    $fatal(1, "copy_source: full copy needs CC_COPY_W >= CC_DATA_W");
  end
  if (MODE == CM_PARITY && `CC_COPY_W < `CC_STRB_W) begin : g_chk_parity
    $fatal(1, "copy_source: parity copy needs CC_COPY_W >= CC_STRB_W");
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // original stream passes through, copy ready follows it

  assign in_ready_o   = ready_i;
  assign orig_valid_o = in_valid_i;
  assign orig_beat_o  = in_beat_i;

  assign accept     = in_valid_i & ready_i;
  assign corrupt    = accept & inject_i;  // only on a real transfer
  assign copy_clean = copy_of(in_beat_i, MODE);

  // copy side, flip the lowest bit the mode actually carries
  always_comb begin
    copy_valid_o = in_valid_i;
    copy_beat_o  = copy_clean;
    if (corrupt) begin
      case (MODE)
        CM_FULL, CM_PARITY: copy_beat_o.cdata[0] = ~copy_clean.cdata[0];
        CM_STRB:            copy_beat_o.cstrb[0] = ~copy_clean.cstrb[0];
        default:            copy_valid_o = 1'b0;  // nothing but the valid to hit
      endcase
    end
  end

endmodule

/* design/stream_pkg.sv */
// beat structs for the original stream and its reduced copy, imported by RTL and testbench
`include "copy_chain_cfg.svh"

package stream_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // original stream payload

  typedef struct packed {
    logic [`CC_DATA_W-1:0] data;  // payload word
    logic [`CC_STRB_W-1:0] strb;  // byte enables
  } orig_beat_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // copy stream payload
  // travels beside the original in its own registers,
  // the meaning of cdata depends on the copy mode

  typedef struct packed {
    logic [`CC_COPY_W-1:0] cdata;  // full data, parity bits or zero
    logic [`CC_STRB_W-1:0] cstrb;  // strobe copy or zero
  } copy_beat_t;

  // handy widths for users that size things off the structs
  localparam int unsigned ORIG_BEAT_W = $bits(orig_beat_t);
  localparam int unsigned COPY_BEAT_W = $bits(copy_beat_t);

endpackage

/* verification/copy_chain_asserts.sv */
// concurrent checks on the copy chain outputs, bound into every copy_chain_top instance
`timescale 1ns/1ps

module copy_chain_asserts import stream_pkg::*; (
  input logic       clk_i,
  input logic       rst_ni,
  input logic       out_valid_i,
  input logic       out_ready_i,
  input orig_beat_t out_beat_i,
  input logic       clear_i,
  input logic       fault_i,
  input logic       alarm_i
);

  // a stalled beat stays at the output unchanged
  stall_hold_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_beat_i))
    else $error("output beat changed or vanished while stalled");

  // sticky alarm only drops through clear
  alarm_sticky_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(alarm_i) |-> $past(clear_i))
    else $error("alarm fell without a clear");

  alarm_reset_a : assert property (@(posedge clk_i)
    $rose(rst_ni) |-> !fault_i && !alarm_i)  // first cycle out of reset
    else $error("fault or alarm high right after reset");

endmodule

bind copy_chain_top copy_chain_asserts u_asserts (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .out_valid_i (out_valid_o),
  .out_ready_i (out_ready_i),
  .out_beat_i  (out_beat_o),
  .clear_i     (clear_i),
  .fault_i     (fault_o),
  .alarm_i     (alarm_o)
);

/* verification/copy_chain_tb.sv */
// testbench for the copy chain top with random traffic, stalls, fault injection and a fault model
`timescale 1ns/1ps
`include "copy_chain_cfg.svh"

module copy_chain_tb import stream_pkg::*, copy_pkg::*; ();

  localparam int WAIT_MAX = 200;  // cycles any single wait may take

  typedef struct packed {
    orig_beat_t beat;
    logic       inj;  // copy of this beat was corrupted at the source
  } sent_t;

  logic       clk_i, rst_ni, in_valid_i, in_ready_o, inject_i;
  logic       out_valid_o, out_ready_i, clear_i, fault_o, alarm_o;
  orig_beat_t in_beat_i, out_beat_o;
  logic       rand_ready, hold_ready, rand_now, hold_now;  // out_ready control
  logic       exp_fault, exp_alarm, mis;
  sent_t      sent_q[$];  // accepted but not yet out
  int         cyc, accept_cyc[$], leave_cyc[$];

  copy_chain_top #(.MODE(CM_PARITY)) dut0 (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .in_valid_i(in_valid_i), .in_ready_o(in_ready_o), .in_beat_i(in_beat_i),
    .inject_i(inject_i),
    .out_valid_o(out_valid_o), .out_ready_i(out_ready_i), .out_beat_o(out_beat_o),
    .clear_i(clear_i), .fault_o(fault_o), .alarm_o(alarm_o)
  );

  always #4 clk_i = ~clk_i;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model and helpers

  // parity copy with one bit per byte plus the strobe
  function automatic copy_beat_t ref_copy(input orig_beat_t b);
    copy_beat_t c;
    c = '0;
    for (int k = 0; k < `CC_STRB_W; k++) begin
      c.cdata[k] = ^b.data[8*k +: 8];
    end
    c.cstrb = b.strb;
    return c;
  endfunction

  function automatic copy_beat_t sent_copy(input sent_t s);
    copy_beat_t c;
    c = ref_copy(s.beat);
    c.cdata[0] = c.cdata[0] ^ s.inj;  // what the source let travel
    return c;
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      stop_run($sformatf("error %s: expected %0h, actual %0h", name, exp, act));
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus tasks are entered and left 1 ns after a rising edge

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic send_beat(input logic inj);
    int         waited;
    logic [31:0] r;
    r = $urandom;
    in_valid_i     = 1'b1;
    in_beat_i.data = $urandom;
    in_beat_i.strb = r[`CC_STRB_W-1:0];
    inject_i       = inj;
    waited         = 0;
    do begin
      @(negedge clk_i);
      waited++;
      if (waited > WAIT_MAX) stop_run("input beat was never accepted");
    end while (!in_ready_o);
    @(posedge clk_i);  // beat taken here
    #1;
    in_valid_i = 1'b0;
    inject_i   = 1'b0;
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (sent_q.size() != 0) begin
      @(negedge clk_i);
      waited++;
      if (waited > WAIT_MAX) stop_run("chain did not drain in time");
    end
    idle(1);
  endtask

  // returns at the negedge where fault_o shows the level
  task automatic wait_fault(input logic level);
    int waited;
    waited = 0;
    do begin
      @(negedge clk_i);
      waited++;
      if (waited > WAIT_MAX) stop_run("fault output never reached the expected level");
    end while (fault_o !== level);
  endtask

  // random or fixed downstream ready with the mode sampled on the edge
  always @(posedge clk_i) begin
    rand_now = rand_ready;
    hold_now = hold_ready;
    #1;
    out_ready_i = rand_now ? ($urandom_range(0, 3) != 0) : hold_now;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // compare process sampling at the falling edge

  always @(negedge clk_i) begin
    if (rst_ni) begin
      cyc++;
      check("fault", 64'(exp_fault), 64'(fault_o));
      check("alarm", 64'(exp_alarm), 64'(alarm_o));
      mis = 1'b0;
      if (out_valid_o) begin
        if (sent_q.size() == 0) stop_run("output beat appeared that was never sent");
        mis = (sent_copy(sent_q[0]) != ref_copy(out_beat_o));
        if (out_ready_i) begin
          check("out_beat", 64'(sent_q[0].beat), 64'(out_beat_o));
          void'(sent_q.pop_front());
          leave_cyc.push_back(cyc);
        end
      end
      exp_fault = mis;                             // shows one cycle later
      if (mis) begin
        exp_alarm = 1'b1;  // a new fault wins over clear
      end else if (clear_i) begin
        exp_alarm = 1'b0;
      end
      if (in_valid_i && in_ready_o) begin
        sent_q.push_back({in_beat_i, inject_i});
        accept_cyc.push_back(cyc);
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // test sequence

  initial begin
    void'($urandom(65));
    clk_i = 1'b0;
    rst_ni = 1'b0;
    in_valid_i = 1'b0;
    in_beat_i = '0;
    inject_i = 1'b0;
    out_ready_i = 1'b0;
    clear_i = 1'b0;
    rand_ready = 1'b0;
    hold_ready = 1'b1;
    exp_fault = 1'b0;
    exp_alarm = 1'b0;
    cyc = 0;
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(negedge clk_i);  // empty chain after reset
    check("reset out_valid", 64'd0, 64'(out_valid_o));
    check("reset in_ready", 64'd1, 64'(in_ready_o));
    idle(1);

    // clean random traffic with stalls on both sides
    rand_ready = 1'b1;
    for (int n = 0; n < 60; n++) begin
      idle($urandom_range(0, 2));
      send_beat(1'b0);
    end
    rand_ready = 1'b0;
    drain();

    // injected beat held at the output until the fault shows
    hold_ready = 1'b0;
    idle(2);
    send_beat(1'b1);
    send_beat(1'b0);
    wait_fault(1'b1);
    check("alarm on fault", 64'd1, 64'(alarm_o));
    check("bad beat still held", 64'd1, 64'(out_valid_o));
    idle(1);
    hold_ready = 1'b1;
    wait_fault(1'b0);  // clean beat behind it
    check("alarm after fault", 64'd1, 64'(alarm_o));
    drain();

    // alarm clear
    clear_i = 1'b1;
    idle(1);
    clear_i = 1'b0;
    @(negedge clk_i);
    check("alarm cleared", 64'd0, 64'(alarm_o));
    idle(3);

    // back to back throughput
    accept_cyc.delete();
    leave_cyc.delete();
    for (int n = 0; n < 8; n++) begin
      send_beat(1'b0);
    end
    drain();
    for (int n = 0; n < 8; n++) begin
      check("latency", 64'(`CC_NUM_SLICES), 64'(leave_cyc[n] - accept_cyc[n]));
      check("out spacing", 64'(leave_cyc[0] + n), 64'(leave_cyc[n]));
    end

    $display(">>> PASS");
    $finish;
  end

endmodule
